// ==== pov_pkg.sv ====
package pov_pkg;

  // rotor geometry
  localparam int ANGLE_COUNT = 64;                 // angle steps in one revolution
  localparam int ANGLE_W     = $clog2(ANGLE_COUNT);
  localparam int SCAN_RATE   = 32;                 // radius positions along one arm
  localparam int RADIUS_W    = $clog2(SCAN_RATE);  // also the panel column number width
  localparam int ARMS        = 2;

  // one radial line of monochrome pixels
  localparam int NUM_ROWS = 16;

  // one frame-buffer entry, written per angle and per arm
  typedef struct packed {
    logic [RADIUS_W-1:0] radius;
    logic [NUM_ROWS-1:0] line;  // bit k is the pixel in row k
  } rfb_entry_t;

  // both arms at one angle, read together on a tick
  typedef struct packed {
    rfb_entry_t arm0;
    rfb_entry_t arm1;
  } rfb_pair_t;

endpackage

// ==== hub75_pkg.sv ====
package hub75_pkg;

  import pov_pkg::*;

  localparam int RGB_RES    = 9;  // 3 bits per channel
  localparam int FIFO_DEPTH = 4;

  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int ROW_W      = $clog2(NUM_ROWS);

  // one panel column ready to shift out, pixels[k] goes out on the k-th shift
  typedef struct packed {
    logic [RADIUS_W-1:0]                col_num;
    logic [NUM_ROWS-1:0][RGB_RES-1:0]   pixels;
  } column_t;

  typedef struct packed {
    logic [RGB_RES-1:0]  rgb;
    logic                sclk;
    logic                latch;
    logic [RADIUS_W-1:0] addr;
  } hub75_pins_t;

  typedef enum logic [1:0] {CONV_IDLE, CONV_EMIT0, CONV_EMIT1} conv_state_e;

  typedef enum logic [1:0] {DRV_IDLE, DRV_FETCH, DRV_SHIFT, DRV_LATCH} drv_state_e;

endpackage

// ==== rfb_store.sv ====
`timescale 1ns/1ps

module rfb_store (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         wr_en,
  input  logic [pov_pkg::ANGLE_W-1:0]  wr_angle,
  input  logic                         wr_arm,
  input  pov_pkg::rfb_entry_t          wr_entry,
  input  logic                         angle_tick,
  output pov_pkg::rfb_pair_t           pair,
  output logic                         pair_valid
);

  import pov_pkg::*;

  rfb_entry_t bank [ARMS][ANGLE_COUNT];  // one bank per arm, indexed by angle

  logic [ANGLE_W-1:0] angle;
  logic [ANGLE_W-1:0] angle_next;

  assign angle_next = (angle == ANGLE_W'(ANGLE_COUNT - 1)) ? '0 : angle + 1'b1;

  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      bank[wr_arm][wr_angle] <= wr_entry;
    end
  end

  // the read sees the stepped angle, so a tick presents the next line of the revolution
  always_ff @(posedge clk_in) begin
    if (angle_tick) begin
      pair.arm0 <= bank[0][angle_next];
      pair.arm1 <= bank[1][angle_next];
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      angle      <= '0;
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= angle_tick;
      if (angle_tick) begin
        angle <= angle_next;
      end
    end
  end

  // the converter needs at least one idle cycle between pairs to latch them
  a_pair_valid_pulse: assert property (
    @(posedge clk_in) disable iff (rst_in)
    pair_valid |=> !pair_valid
  ) else $error("pair_valid high in two consecutive cycles");

endmodule

// ==== rfb_to_hub75.sv ====
`timescale 1ns/1ps

module rfb_to_hub75 (
  input  logic                clk_in,
  input  logic                rst_in,
  input  pov_pkg::rfb_pair_t  pair,
  input  logic                pair_valid,
  input  logic                full,
  output logic                push,
  output hub75_pkg::column_t  push_col,
  output logic                overrun
);

  import pov_pkg::*;
  import hub75_pkg::*;

  conv_state_e state;
  rfb_pair_t   pair_q;
  column_t     col_arm0;
  column_t     col_arm1;

  // a set pixel lights all colour bits, the buffer is monochrome
  function automatic column_t expand(input rfb_entry_t e, input logic [RADIUS_W-1:0] col);
    column_t c;
    c.col_num = col;
    for (int r = 0; r < NUM_ROWS; r++) begin
      c.pixels[r] = {RGB_RES{e.line[r]}};
    end
    return c;
  endfunction

  assign col_arm0 = expand(pair_q.arm0, pair_q.arm0.radius);
  // arm 1 points the other way, so its radius counts down the panel
  assign col_arm1 = expand(pair_q.arm1, RADIUS_W'(SCAN_RATE - 1) - pair_q.arm1.radius);

  assign push     = (state != CONV_IDLE) && !full;  // full is the ready level
  assign push_col = (state == CONV_EMIT1) ? col_arm1 : col_arm0;

  always_ff @(posedge clk_in) begin
    if (state == CONV_IDLE && pair_valid) begin
      pair_q <= pair;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state   <= CONV_IDLE;
      overrun <= 1'b0;
    end else begin
      case (state)
        CONV_IDLE: begin
          if (pair_valid) state <= CONV_EMIT0;
        end
        CONV_EMIT0: begin
          if (!full) state <= CONV_EMIT1;
        end
        CONV_EMIT1: begin
          if (!full) state <= CONV_IDLE;
        end
        default: state <= CONV_IDLE;
      endcase
      if (pair_valid && state != CONV_IDLE) begin
        overrun <= 1'b1;  // pair dropped, sticky until reset
      end
    end
  end

  a_no_push_when_full: assert property (
    @(posedge clk_in) disable iff (rst_in)
    full |-> !push
  ) else $error("push while the queue is full");

endmodule

// ==== column_fifo.sv ====
`timescale 1ns/1ps

module column_fifo (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                push,
  input  hub75_pkg::column_t  push_col,
  input  logic                pop,
  output hub75_pkg::column_t  pop_col,
  output logic                full,
  output logic                empty
);

  import hub75_pkg::*;

  column_t mem [FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  wr_fire;
  logic                  rd_fire;

  assign full    = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign wr_fire = push && !full;
  assign rd_fire = pop && !empty;

  always_ff @(posedge clk_in) begin
    if (wr_fire) mem[wr_ptr] <= push_col;
    if (rd_fire) pop_col <= mem[rd_ptr];  // word shows up the cycle after pop
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_push_not_full: assert property (@(posedge clk_in) disable iff (rst_in) push |-> !full)
    else $error("fifo push while full");
  a_pop_not_empty: assert property (@(posedge clk_in) disable iff (rst_in) pop |-> !empty)
    else $error("fifo pop while empty");

endmodule

// ==== hub75_driver.sv ====
`timescale 1ns/1ps

module hub75_driver (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   empty,
  output logic                   pop,
  input  hub75_pkg::column_t     pop_col,
  output hub75_pkg::hub75_pins_t pins
);

  import pov_pkg::*;
  import hub75_pkg::*;

  drv_state_e       state;
  logic [ROW_W-1:0] row;

  assign pop = (state == DRV_FETCH);

  // pop_col stays put until the next pop, so it is read straight from the queue
  always_comb begin
    pins.sclk  = (state == DRV_SHIFT);
    pins.latch = (state == DRV_LATCH);
    pins.rgb   = pins.sclk ? pop_col.pixels[row] : '0;
    pins.addr  = pop_col.col_num;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= DRV_IDLE;
      row   <= '0;
    end else begin
      case (state)
        DRV_IDLE: begin
          if (!empty) state <= DRV_FETCH;
        end
        DRV_FETCH: begin
          row   <= '0;
          state <= DRV_SHIFT;
        end
        DRV_SHIFT: begin
          if (row == ROW_W'(NUM_ROWS - 1)) begin
            row   <= '0;
            state <= DRV_LATCH;
          end else begin
            row <= row + 1'b1;
          end
        end
        DRV_LATCH: begin
          // go straight to the next word when one is waiting, no idle gap
          state <= empty ? DRV_IDLE : DRV_FETCH;
        end
        default: state <= DRV_IDLE;
      endcase
    end
  end

  a_latch_sclk_excl: assert property (
    @(posedge clk_in) disable iff (rst_in)
    !(pins.latch && pins.sclk)
  ) else $error("latch and sclk high together");

endmodule

// ==== pov_display_top.sv ====
`timescale 1ns/1ps

module pov_display_top (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         wr_en,
  input  logic [pov_pkg::ANGLE_W-1:0]  wr_angle,
  input  logic                         wr_arm,
  input  pov_pkg::rfb_entry_t          wr_entry,
  input  logic                         angle_tick,
  output hub75_pkg::hub75_pins_t       pins,
  output logic                         overrun
);

  import pov_pkg::*;
  import hub75_pkg::*;

  rfb_pair_t pair;
  logic      pair_valid;
  logic      push;
  column_t   push_col;
  logic      full;
  logic      pop;
  column_t   pop_col;
  logic      empty;

  rfb_store u_rfb_store (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .wr_en      (wr_en),
    .wr_angle   (wr_angle),
    .wr_arm     (wr_arm),
    .wr_entry   (wr_entry),
    .angle_tick (angle_tick),
    .pair       (pair),
    .pair_valid (pair_valid)
  );

  rfb_to_hub75 u_rfb_to_hub75 (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .pair       (pair),
    .pair_valid (pair_valid),
    .full       (full),
    .push       (push),
    .push_col   (push_col),
    .overrun    (overrun)
  );

  column_fifo u_column_fifo (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .push     (push),
    .push_col (push_col),
    .pop      (pop),
    .pop_col  (pop_col),
    .full     (full),
    .empty    (empty)
  );

  hub75_driver u_hub75_driver (
    .clk_in  (clk_in),
    .rst_in  (rst_in),
    .empty   (empty),
    .pop     (pop),
    .pop_col (pop_col),
    .pins    (pins)
  );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk_in
);

  localparam int HALF_PERIOD = 4;  // 8 ns period

  initial clk_in = 1'b0;

  always #(HALF_PERIOD) clk_in = ~clk_in;

endmodule

// ==== pov_display_tb.sv ====
`timescale 1ns/1ps

module pov_display_tb;

  import pov_pkg::*;
  import hub75_pkg::*;

  localparam int COL_CYCLES   = NUM_ROWS + 2;  // fetch, row shifts, latch
  localparam int TICK_GAP     = 2 * COL_CYCLES + 4;
  localparam int WRAP_TICKS   = ANGLE_COUNT + 3;
  localparam int NEW_TICKS    = 20;
  localparam int STALL_ROUNDS = 4;
  localparam int TAIL_TICKS   = 4;
  localparam int TOTAL_TICKS  = 1 + WRAP_TICKS + NEW_TICKS + 3 * STALL_ROUNDS + 2 + TAIL_TICKS;
  localparam int CYCLE_LIMIT  = 4 * (TOTAL_TICKS * 2 * COL_CYCLES) + 200;

  // what the panel should show for one column word
  typedef struct packed {
    logic [RADIUS_W-1:0] addr;
    logic [NUM_ROWS-1:0] line;
  } exp_col_t;

  logic               clk_in;
  logic               rst_in;
  logic               wr_en;
  logic [ANGLE_W-1:0] wr_angle;
  logic               wr_arm;
  rfb_entry_t         wr_entry;
  logic               angle_tick;
  hub75_pins_t        pins;
  logic               overrun;

  rfb_entry_t         model_mem [ARMS][ANGLE_COUNT];
  int                 model_angle = 0;
  exp_col_t           exp_q [$];
  logic [RGB_RES-1:0] shifted [NUM_ROWS];
  int                 row_cnt = 0;
  int                 cycles = 0;

  tb_clock u_clock (.clk_in(clk_in));

  pov_display_top DUT (.*);

  task automatic value_error(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic abort_with(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  // arm 1 faces the other way, so its radius counts back from the outer column
  function automatic exp_col_t column_of(input int arm, input rfb_entry_t e);
    exp_col_t c;
    c.line = e.line;
    c.addr = (arm == 0) ? e.radius : RADIUS_W'(SCAN_RATE - 1 - int'(e.radius));
    return c;
  endfunction

  function automatic rfb_entry_t random_entry();
    rfb_entry_t e;
    e.radius = RADIUS_W'($urandom_range(SCAN_RATE - 1, 0));
    e.line   = NUM_ROWS'($urandom());
    return e;
  endfunction

  task automatic write_entry(input int angle, input int arm, input rfb_entry_t e);
    wr_en    = 1'b1;
    wr_angle = ANGLE_W'(angle);
    wr_arm   = arm[0];
    wr_entry = e;
    model_mem[arm][angle] = e;
    @(negedge clk_in);
    wr_en = 1'b0;
  endtask

  task automatic pulse_tick(input bit dropped);
    angle_tick  = 1'b1;
    model_angle = (model_angle + 1) % ANGLE_COUNT;  // counter steps even on a dropped pair
    if (!dropped) begin
      exp_q.push_back(column_of(0, model_mem[0][model_angle]));
      exp_q.push_back(column_of(1, model_mem[1][model_angle]));
    end
    @(negedge clk_in);
    angle_tick = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk_in);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk_in);
    idle(4);
  endtask

  // collects the shifted rows of one column and checks them at the latch
  always @(posedge clk_in) begin : bus_monitor
    exp_col_t           exp;
    logic [RGB_RES-1:0] want;
    if (!rst_in && pins.sclk) begin
      assert (row_cnt < NUM_ROWS) else value_error("more row shifts than rows before a latch");
      shifted[row_cnt] = pins.rgb;
      row_cnt++;
    end
    if (!rst_in && pins.latch) begin
      assert (exp_q.size() != 0) else abort_with("a column was latched while none was expected");
      exp = exp_q.pop_front();
      assert (row_cnt == NUM_ROWS)
        else value_error($sformatf("latch after %0d row shifts", row_cnt));
      assert (pins.addr == exp.addr)
        else value_error($sformatf("addr %0d, expected %0d", pins.addr, exp.addr));
      for (int k = 0; k < NUM_ROWS; k++) begin
        want = exp.line[k] ? {RGB_RES{1'b1}} : '0;
        assert (shifted[k] == want) else value_error(
          $sformatf("col %0d row %0d rgb %h, expected %h", exp.addr, k, shifted[k], want));
      end
      row_cnt = 0;
    end
  end

  always @(posedge clk_in) begin
    cycles++;
    assert (cycles < CYCLE_LIMIT) else abort_with(
      $sformatf("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT));
  end

  initial begin
    int n;
    void'($urandom(32'h2fc7_1627));
    rst_in     = 1'b1;
    wr_en      = 1'b0;
    wr_angle   = '0;
    wr_arm     = 1'b0;
    wr_entry   = '0;
    angle_tick = 1'b0;
    idle(3);
    rst_in = 1'b0;
    idle(2);

    for (int a = 0; a < ANGLE_COUNT; a++) begin
      for (int arm = 0; arm < ARMS; arm++) write_entry(a, arm, random_entry());
    end
    pulse_tick(1'b0);
    wait_drain();

    // a full revolution and a bit, the model starts at angle 1 as well
    for (int t = 0; t < WRAP_TICKS; t++) begin
      pulse_tick(1'b0);
      idle(TICK_GAP - 1);
    end
    wait_drain();
    assert (overrun == 1'b0) else value_error("overrun set with widely spaced ticks");

    for (int t = 0; t < NEW_TICKS; t++) begin
      n = $urandom_range(3, 1);
      repeat (n) write_entry($urandom_range(ANGLE_COUNT - 1, 0), $urandom_range(1, 0),
                             random_entry());
      write_entry((model_angle + 1) % ANGLE_COUNT, $urandom_range(1, 0), random_entry());
      pulse_tick(1'b0);
      idle(TICK_GAP - n - 2);
    end
    wait_drain();

    // three quick ticks fill the queue and stall the converter, one more would overrun
    for (int r = 0; r < STALL_ROUNDS; r++) begin
      repeat (3) begin
        pulse_tick(1'b0);
        idle(2);
      end
      wait_drain();
    end
    assert (overrun == 1'b0) else value_error("overrun set while the queue stalled the converter");

    pulse_tick(1'b0);
    idle(1);
    pulse_tick(1'b1);  // the converter is still emitting the first pair
    wait_drain();
    assert (overrun == 1'b1) else value_error("overrun not set after a pair came in while busy");
    for (int t = 0; t < TAIL_TICKS; t++) begin
      pulse_tick(1'b0);
      idle(TICK_GAP - 1);
    end
    wait_drain();
    assert (overrun == 1'b1) else value_error("overrun cleared without a reset");

    if (exp_q.size() == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      abort_with("expected columns were still outstanding at the end of the run");
    end
  end

endmodule

// ==== vlog.f ====
pov_pkg.sv
hub75_pkg.sv
rfb_store.sv
rfb_to_hub75.sv
column_fifo.sv
hub75_driver.sv
pov_display_top.sv
tb_clock.sv
pov_display_tb.sv

// ==== Bender.yml ====
package:
  name: pov_display

sources:
  - pov_pkg.sv
  - hub75_pkg.sv
  - rfb_store.sv
  - rfb_to_hub75.sv
  - column_fifo.sv
  - hub75_driver.sv
  - pov_display_top.sv
  - target: test
    files:
      - tb_clock.sv
      - pov_display_tb.sv
